/* exe_pkg.sv */
package exe_pkg;

    // datapath width, fixed by the ISA
    localparam int XLEN = 32;

    // integer ALU opcodes
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    // quotient truncates toward zero, remainder follows the dividend sign
    typedef enum logic [2:0] {
        div_none,
        div_s,
        div_u,
        mod_s,
        mod_u
    } div_op_e;

    typedef enum logic [3:0] {
        mem_none,
        ld_b,
        ld_bu,
        ld_h,
        ld_hu,
        ld_w,
        st_b,
        st_h,
        st_w
    } mem_op_e;

    // encoding as seen on the data SRAM port
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

endpackage

/* exe_stage_reg.sv */
`timescale 1ns/1ps

module exe_stage_reg import exe_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            in_valid,
    input  alu_op_e         in_alu_op,
    input  div_op_e         in_div_op,
    input  mem_op_e         in_mem_op,
    input  logic [XLEN-1:0] in_src1,
    input  logic [XLEN-1:0] in_src2,
    input  logic [XLEN-1:0] in_store_val,
    input  logic [4:0]      in_dest,
    input  logic [XLEN-1:0] in_pc,
    input  logic            mem_ready,
    input  logic            div_done,
    input  logic            ms_allowin,
    output logic            es_valid,
    output logic            es_allowin,
    output logic            out_valid,
    output alu_op_e         es_alu_op,
    output div_op_e         es_div_op,
    output mem_op_e         es_mem_op,
    output logic [XLEN-1:0] es_src1,
    output logic [XLEN-1:0] es_src2,
    output logic [XLEN-1:0] es_store_val,
    output logic [4:0]      es_dest,
    output logic [XLEN-1:0] es_pc
);

    logic ready_go;

    // memory ops wait for the SRAM, divides for the divider
    always_comb begin
        if (es_mem_op != mem_none) begin
            ready_go = mem_ready;
        end else if (es_div_op != div_none) begin
            ready_go = div_done;
        end else begin
            ready_go = 1'b1;
        end
    end

    // a flushed instruction must not reach the memory stage
    assign out_valid  = es_valid & ready_go & ~flush;
    assign es_allowin = ~es_valid | (ready_go & ms_allowin);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && es_allowin) begin
            es_alu_op    <= in_alu_op;
            es_div_op    <= in_div_op;
            es_mem_op    <= in_mem_op;
            es_src1      <= in_src1;
            es_src2      <= in_src2;
            es_store_val <= in_store_val;
            es_dest      <= in_dest;
            es_pc        <= in_pc;
        end
    end

endmodule

/* exe_alu.sv */
`timescale 1ns/1ps

module exe_alu import exe_pkg::*; (
    input  alu_op_e         alu_op,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    output logic [XLEN-1:0] alu_sum,
    output logic [XLEN-1:0] alu_result
);

    logic [XLEN-1:0]         diff;
    logic                    borrow;
    logic                    lt_signed;
    logic                    lt_unsigned;
    logic [$clog2(XLEN)-1:0] shamt;

    assign alu_sum = src1 + src2;

    // one subtractor serves sub and both compares
    assign {borrow, diff} = {1'b0, src1} - {1'b0, src2};
    assign lt_unsigned    = borrow;
    assign lt_signed      = (src1[XLEN-1] != src2[XLEN-1]) ? src1[XLEN-1] : diff[XLEN-1];

    assign shamt = src2[$clog2(XLEN)-1:0];

    always_comb begin
        case (alu_op)
            alu_add: begin
                alu_result = alu_sum;
            end
            alu_sub: begin
                alu_result = diff;
            end
            alu_slt: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            end
            alu_and: begin
                alu_result = src1 & src2;
            end
            alu_or: begin
                alu_result = src1 | src2;
            end
            alu_xor: begin
                alu_result = src1 ^ src2;
            end
            alu_nor: begin
                alu_result = ~(src1 | src2);
            end
            alu_sll: begin
                alu_result = src1 << shamt;
            end
            alu_srl: begin
                alu_result = src1 >> shamt;
            end
            alu_sra: begin
                alu_result = $unsigned($signed(src1) >>> shamt);
            end
            // immediate already placed by decode
            alu_lui: begin
                alu_result = src2;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

/* exe_div.sv */
`timescale 1ns/1ps

module exe_div import exe_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            es_valid,
    input  div_op_e         div_op,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    output logic            done,
    output logic [XLEN-1:0] div_result
);

    localparam int STEP_W = $clog2(XLEN);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(XLEN - 1);

    typedef enum logic [1:0] {
        div_idle,
        div_busy,
        div_done
    } div_state_e;

    div_state_e        state;
    logic [STEP_W-1:0] step;
    logic [XLEN-1:0]   quo;
    logic [XLEN-1:0]   rem;
    logic              is_signed;
    logic              is_mod;
    logic              neg_dividend;
    logic              neg_divisor;
    logic [XLEN-1:0]   abs_dividend;
    logic [XLEN-1:0]   abs_divisor;
    logic [XLEN:0]     trial;
    logic [XLEN-1:0]   quo_fix;
    logic [XLEN-1:0]   rem_fix;

    // operands stay stable in the stage register for the whole divide
    assign is_signed    = (div_op == div_s) || (div_op == mod_s);
    assign is_mod       = (div_op == mod_s) || (div_op == mod_u);
    assign neg_dividend = is_signed & dividend[XLEN-1];
    assign neg_divisor  = is_signed & divisor[XLEN-1];
    assign abs_dividend = neg_dividend ? -dividend : dividend;
    assign abs_divisor  = neg_divisor ? -divisor : divisor;

    // shift in the next dividend bit and try the subtract
    assign trial = {rem, quo[XLEN-1]} - {1'b0, abs_divisor};

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state <= div_idle;
        end else begin
            case (state)
                div_idle: begin
                    if (es_valid && div_op != div_none) begin
                        state <= div_busy;
                    end
                end
                div_busy: begin
                    if (step == LAST_STEP) begin
                        state <= div_done;
                    end
                end
                // hold the result until the stage lets go of it
                div_done: begin
                    if (!es_valid) begin
                        state <= div_idle;
                    end
                end
                default: begin
                    state <= div_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == div_idle) begin
            rem  <= '0;
            quo  <= abs_dividend;
            step <= '0;
        end else if (state == div_busy) begin
            step <= step + 1'b1;
            if (!trial[XLEN]) begin
                rem <= trial[XLEN-1:0];
                quo <= {quo[XLEN-2:0], 1'b1};
            end else begin
                rem <= {rem[XLEN-2:0], quo[XLEN-1]};
                quo <= {quo[XLEN-2:0], 1'b0};
            end
        end
    end

    assign quo_fix    = (neg_dividend ^ neg_divisor) ? -quo : quo;
    assign rem_fix    = neg_dividend ? -rem : rem;
    assign div_result = is_mod ? rem_fix : quo_fix;
    assign done       = (state == div_done);

endmodule

/* exe_mem_req.sv */
`timescale 1ns/1ps

module exe_mem_req import exe_pkg::*; (
    input  logic            es_valid,
    input  mem_op_e         mem_op,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] store_val,
    input  logic            ms_allowin,
    input  logic            flush,
    input  logic            data_sram_addr_ok,
    output logic            ale,
    output logic            mem_ready,
    output logic            data_sram_en,
    output logic [3:0]      data_sram_wen,
    output mem_size_e       data_sram_size,
    output logic [XLEN-1:0] data_sram_addr,
    output logic [XLEN-1:0] data_sram_wdata
);

    logic      is_mem;
    logic      is_store;
    mem_size_e size;
    logic [3:0] strobe;

    always_comb begin
        is_store = 1'b0;
        case (mem_op)
            ld_h, ld_hu: begin
                size = size_half;
            end
            ld_w: begin
                size = size_word;
            end
            st_b: begin
                size     = size_byte;
                is_store = 1'b1;
            end
            st_h: begin
                size     = size_half;
                is_store = 1'b1;
            end
            st_w: begin
                size     = size_word;
                is_store = 1'b1;
            end
            default: begin
                size = size_byte;
            end
        endcase
    end

    assign is_mem = (mem_op != mem_none);
    assign ale    = is_mem && ((size == size_half && addr[0]) ||
                               (size == size_word && addr[1:0] != 2'b00));

    // byte lanes and replicated store data
    always_comb begin
        case (size)
            size_half: begin
                strobe          = addr[1] ? 4'b1100 : 4'b0011;
                data_sram_wdata = {2{store_val[15:0]}};
            end
            size_word: begin
                strobe          = 4'b1111;
                data_sram_wdata = store_val;
            end
            default: begin
                strobe          = 4'b0001 << addr[1:0];
                data_sram_wdata = {4{store_val[7:0]}};
            end
        endcase
    end

    // request only when the memory stage can take the result
    assign data_sram_en   = es_valid & is_mem & ~ale & ms_allowin & ~flush;
    assign mem_ready      = ale | (data_sram_en & data_sram_addr_ok);
    assign data_sram_wen  = is_store ? strobe : 4'b0000;
    assign data_sram_size = size;
    assign data_sram_addr = addr;

endmodule

/* exe_stage.sv */
`timescale 1ns/1ps

module exe_stage import exe_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    // from decode
    input  logic            in_valid,
    input  alu_op_e         in_alu_op,
    input  div_op_e         in_div_op,
    input  mem_op_e         in_mem_op,
    input  logic [XLEN-1:0] in_src1,
    input  logic [XLEN-1:0] in_src2,
    input  logic [XLEN-1:0] in_store_val,
    input  logic [4:0]      in_dest,
    input  logic [XLEN-1:0] in_pc,
    output logic            es_allowin,
    // to memory stage
    output logic            out_valid,
    output logic [XLEN-1:0] out_result,
    output logic [4:0]      out_dest,
    output mem_op_e         out_mem_op,
    output logic [XLEN-1:0] out_pc,
    output logic            out_ale,
    input  logic            ms_allowin,
    // data SRAM
    output logic            data_sram_en,
    output logic [3:0]      data_sram_wen,
    output mem_size_e       data_sram_size,
    output logic [XLEN-1:0] data_sram_addr,
    output logic [XLEN-1:0] data_sram_wdata,
    input  logic            data_sram_addr_ok
);

    logic            es_valid;
    alu_op_e         es_alu_op;
    div_op_e         es_div_op;
    mem_op_e         es_mem_op;
    logic [XLEN-1:0] es_src1;
    logic [XLEN-1:0] es_src2;
    logic [XLEN-1:0] es_store_val;
    logic [XLEN-1:0] alu_sum;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] div_result;
    logic            div_done;
    logic            div_active;
    logic            mem_ready;

    exe_stage_reg u_stage_reg (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .in_valid     (in_valid),
        .in_alu_op    (in_alu_op),
        .in_div_op    (in_div_op),
        .in_mem_op    (in_mem_op),
        .in_src1      (in_src1),
        .in_src2      (in_src2),
        .in_store_val (in_store_val),
        .in_dest      (in_dest),
        .in_pc        (in_pc),
        .mem_ready    (mem_ready),
        .div_done     (div_done),
        .ms_allowin   (ms_allowin),
        .es_valid     (es_valid),
        .es_allowin   (es_allowin),
        .out_valid    (out_valid),
        .es_alu_op    (es_alu_op),
        .es_div_op    (es_div_op),
        .es_mem_op    (es_mem_op),
        .es_src1      (es_src1),
        .es_src2      (es_src2),
        .es_store_val (es_store_val),
        .es_dest      (out_dest),
        .es_pc        (out_pc)
    );

    exe_alu u_alu (
        .alu_op     (es_alu_op),
        .src1       (es_src1),
        .src2       (es_src2),
        .alu_sum    (alu_sum),
        .alu_result (alu_result)
    );

    // divider releases its result on the transfer edge, so back-to-back divides restart
    assign div_active = es_valid & ~(out_valid & ms_allowin);

    exe_div u_div (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .es_valid   (div_active),
        .div_op     (es_div_op),
        .dividend   (es_src1),
        .divisor    (es_src2),
        .done       (div_done),
        .div_result (div_result)
    );

    exe_mem_req u_mem_req (
        .es_valid          (es_valid),
        .mem_op            (es_mem_op),
        .addr              (alu_sum),
        .store_val         (es_store_val),
        .ms_allowin        (ms_allowin),
        .flush             (flush),
        .data_sram_addr_ok (data_sram_addr_ok),
        .ale               (out_ale),
        .mem_ready         (mem_ready),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_size    (data_sram_size),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata)
    );

    assign out_mem_op = es_mem_op;
    assign out_result = (es_div_op != div_none) ? div_result : alu_result;

endmodule

/* exe_stage_chk.sv */
`timescale 1ns/1ps

module exe_stage_chk import exe_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic            flush,
    input logic            out_valid,
    input logic [XLEN-1:0] out_result,
    input logic [4:0]      out_dest,
    input mem_op_e         out_mem_op,
    input logic [XLEN-1:0] out_pc,
    input logic            out_ale,
    input logic            ms_allowin,
    input logic            data_sram_en,
    input logic [3:0]      data_sram_wen,
    input mem_size_e       data_sram_size,
    input logic [XLEN-1:0] data_sram_addr
);

    a_quiet_after_reset: assert property (
        @(posedge clk) reset |=> !out_valid && !data_sram_en
    ) else $error("stage active in the cycle after reset");

    // a stalled result stays put unless the stage is cancelled
    a_hold_while_stalled: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !ms_allowin |=> flush || (out_valid && $stable(out_result) &&
            $stable(out_dest) && $stable(out_mem_op) && $stable(out_pc) && $stable(out_ale))
    ) else $error("stage outputs changed while the memory stage was stalled");

    // address on the port must be a multiple of the access size
    a_no_misaligned_request: assert property (
        @(posedge clk) data_sram_en |-> !out_ale &&
            ((data_sram_addr & ((32'd1 << data_sram_size) - 32'd1)) == '0)
    ) else $error("data SRAM request made for a misaligned access");

    a_load_no_write: assert property (
        @(posedge clk) data_sram_en && (out_mem_op inside {ld_b, ld_bu, ld_h, ld_hu, ld_w})
        |-> data_sram_wen == 4'b0000
    ) else $error("write strobe set for a load");

endmodule

bind exe_stage exe_stage_chk u_chk (
    .clk            (clk),
    .reset          (reset),
    .flush          (flush),
    .out_valid      (out_valid),
    .out_result     (out_result),
    .out_dest       (out_dest),
    .out_mem_op     (out_mem_op),
    .out_pc         (out_pc),
    .out_ale        (out_ale),
    .ms_allowin     (ms_allowin),
    .data_sram_en   (data_sram_en),
    .data_sram_wen  (data_sram_wen),
    .data_sram_size (data_sram_size),
    .data_sram_addr (data_sram_addr)
);

/* tb_exe_stage.sv */
`timescale 1ns/1ps

module tb_exe_stage import exe_pkg::*; ();

    localparam int              ACCEPT_LIMIT = 200;
    localparam int              DRAIN_LIMIT  = 400;
    localparam logic [XLEN-1:0] PC_BASE      = 32'h1c00_0000;

    typedef struct packed {
        logic [XLEN-1:0] result;
        logic            ale;
        logic [4:0]      dest;
        mem_op_e         mem_op;
        logic [XLEN-1:0] pc;
        logic            has_req;
        logic            is_store;
        logic [3:0]      wen;
        mem_size_e       size;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } txn_t;

    logic            clk;
    logic            reset;
    logic            flush;
    logic            in_valid;
    alu_op_e         in_alu_op;
    div_op_e         in_div_op;
    mem_op_e         in_mem_op;
    logic [XLEN-1:0] in_src1;
    logic [XLEN-1:0] in_src2;
    logic [XLEN-1:0] in_store_val;
    logic [4:0]      in_dest;
    logic [XLEN-1:0] in_pc;
    logic            es_allowin;
    logic            out_valid;
    logic [XLEN-1:0] out_result;
    logic [4:0]      out_dest;
    mem_op_e         out_mem_op;
    logic [XLEN-1:0] out_pc;
    logic            out_ale;
    logic            ms_allowin;
    logic            data_sram_en;
    logic [3:0]      data_sram_wen;
    mem_size_e       data_sram_size;
    logic [XLEN-1:0] data_sram_addr;
    logic [XLEN-1:0] data_sram_wdata;
    logic            data_sram_addr_ok;

    integer seed;
    txn_t   exp_q[$];
    logic   req_seen;
    logic   sram_hold;
    int     issued;

    exe_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // expected stage outputs straight from the ISA rules
    function automatic txn_t expected_result(input alu_op_e aop, input div_op_e dop,
                                             input mem_op_e mop, input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] b,
                                             input logic [XLEN-1:0] sv);
        txn_t t;
        int   nbytes;
        int   base;
        t = '0;
        case (aop)
            alu_add:  t.result = a + b;
            alu_sub:  t.result = a - b;
            alu_slt:  t.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: t.result = (a < b) ? 32'd1 : 32'd0;
            alu_and:  t.result = a & b;
            alu_or:   t.result = a | b;
            alu_xor:  t.result = a ^ b;
            alu_nor:  t.result = ~(a | b);
            alu_sll:  t.result = a << b[4:0];
            alu_srl:  t.result = a >> b[4:0];
            alu_sra:  t.result = $signed(a) >>> b[4:0];
            default:  t.result = b;
        endcase
        case (dop)
            div_s:   t.result = $signed(a) / $signed(b);
            div_u:   t.result = a / b;
            mod_s:   t.result = $signed(a) % $signed(b);
            mod_u:   t.result = a % b;
            default: ;
        endcase
        t.mem_op = mop;
        if (mop != mem_none) begin
            case (mop)
                ld_b, ld_bu, st_b: t.size = size_byte;
                ld_h, ld_hu, st_h: t.size = size_half;
                default:           t.size = size_word;
            endcase
            nbytes     = 1 << t.size;
            t.addr     = a + b;
            t.ale      = (t.addr % nbytes) != 0;
            t.has_req  = !t.ale;
            t.is_store = mop inside {st_b, st_h, st_w};
            base       = t.addr[1:0] & (4 - nbytes);
            for (int i = 0; i < 4; i++) begin
                t.wdata[8*i +: 8] = sv[8*(i % nbytes) +: 8];
                t.wen[i] = t.is_store && i >= base && i < base + nbytes;
            end
        end
        return t;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_dest(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_mem_op(input string name, input mem_op_e got, input mem_op_e exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_size(input string name, input mem_size_e got, input mem_size_e exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_strobe(input string name, input logic [3:0] got,
                                  input logic [3:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_sram_accept();
        txn_t t;
        if (exp_q.size() == 0 || req_seen || !exp_q[0].has_req) begin
            stop_with_failure("data SRAM accepted a request that was not expected");
        end else begin
            t = exp_q[0];
            compare_word("data_sram_addr", data_sram_addr, t.addr);
            compare_strobe("data_sram_wen", data_sram_wen, t.wen);
            compare_size("data_sram_size", data_sram_size, t.size);
            if (t.is_store) begin
                compare_word("data_sram_wdata", data_sram_wdata, t.wdata);
            end
            req_seen = 1'b1;
        end
    endtask

    task automatic check_transfer();
        txn_t t;
        if (exp_q.size() == 0) begin
            stop_with_failure("out_valid transfer with no instruction outstanding");
        end else begin
            t = exp_q.pop_front();
            if (t.has_req && !req_seen) begin
                stop_with_failure("memory op left the stage without an SRAM request");
            end
            compare_word("out_result", out_result, t.result);
            compare_flag("out_ale", out_ale, t.ale);
            compare_dest("out_dest", out_dest, t.dest);
            compare_mem_op("out_mem_op", out_mem_op, t.mem_op);
            compare_word("out_pc", out_pc, t.pc);
            req_seen = 1'b0;
        end
    endtask

    // sample on the rising edge, SRAM accept first since it shares the edge
    always @(posedge clk) begin
        if (!reset) begin
            if (data_sram_en && data_sram_addr_ok) begin
                check_sram_accept();
            end
            if (out_valid && ms_allowin) begin
                check_transfer();
            end
        end
    end

    // memory stage and SRAM models
    always @(negedge clk) begin
        ms_allowin        = (rand_below(4) != 0);
        data_sram_addr_ok = !sram_hold && (rand_below(3) != 0);
    end

    task automatic send_instr(input alu_op_e aop, input div_op_e dop, input mem_op_e mop,
                              input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        txn_t            t;
        logic [XLEN-1:0] sv;
        int              waited;
        sv           = rand_word();
        t            = expected_result(aop, dop, mop, a, b, sv);
        t.dest       = 5'(issued);
        t.pc         = PC_BASE + 32'(issued * 4);
        in_valid     = 1'b1;
        in_alu_op    = aop;
        in_div_op    = dop;
        in_mem_op    = mop;
        in_src1      = a;
        in_src2      = b;
        in_store_val = sv;
        in_dest      = t.dest;
        in_pc        = t.pc;
        waited       = 0;
        @(posedge clk);
        while (!es_allowin) begin
            waited++;
            if (waited > ACCEPT_LIMIT) begin
                stop_with_failure("instruction was not accepted before the timeout");
            end
            @(posedge clk);
        end
        exp_q.push_back(t);
        issued++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // kind 0 is ALU, 1 is divide, anything else a memory op
    task automatic send_random(input int kind);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = rand_word();
        b = rand_word();
        case (kind)
            0: send_instr(alu_op_e'(rand_below(12)), div_none, mem_none, a, b);
            1: begin
                b = $signed(b) >>> rand_below(31);
                if (b == '0) b = 32'd7;
                // most negative over minus one has no result
                if (a == 32'h8000_0000 && b == '1) b = 32'd3;
                send_instr(alu_add, div_op_e'(1 + rand_below(4)), mem_none, a, b);
            end
            default: send_instr(alu_add, div_none, mem_op_e'(1 + rand_below(8)), a,
                                32'(rand_below(16)));
        endcase
        if (rand_below(4) == 0) begin
            @(negedge clk);
        end
    endtask

    task automatic flush_stage(input int delay);
        repeat (delay) @(negedge clk);
        if (exp_q.size() != 1) begin
            stop_with_failure("instruction to be flushed already left the stage");
        end else begin
            flush = 1'b1;
            void'(exp_q.pop_back());
            @(negedge clk);
            flush = 1'b0;
        end
    endtask

    initial begin
        int waited;
        seed              = 32'had0d563e;
        reset             = 1'b1;
        flush             = 1'b0;
        in_valid          = 1'b0;
        in_alu_op         = alu_add;
        in_div_op         = div_none;
        in_mem_op         = mem_none;
        in_src1           = '0;
        in_src2           = '0;
        in_store_val      = '0;
        in_dest           = '0;
        in_pc             = '0;
        ms_allowin        = 1'b0;
        data_sram_addr_ok = 1'b0;
        req_seen          = 1'b0;
        sram_hold         = 1'b0;
        issued            = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < 60; i++) send_random(0);
        for (int i = 0; i < 16; i++) send_random(1);
        for (int i = 0; i < 50; i++) send_random(2);
        for (int i = 0; i < 60; i++) send_random(int'(rand_below(3)));

        // divide cancelled while busy
        send_instr(alu_add, div_s, mem_none, 32'hffff_f000, 32'd7);
        flush_stage(3);
        for (int i = 0; i < 4; i++) send_random(0);

        // store stuck waiting on addr_ok, then cancelled
        sram_hold = 1'b1;
        @(negedge clk);
        send_instr(alu_add, div_none, st_w, rand_word() & ~32'h3, 32'd8);
        flush_stage(2);
        sram_hold = 1'b0;
        for (int i = 0; i < 8; i++) send_random(int'(rand_below(3)));

        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > DRAIN_LIMIT) begin
                stop_with_failure("stage did not drain before the timeout");
            end
            @(negedge clk);
        end
        $display("sim passed");
        $finish;
    end

endmodule

/* project.f */
exe_pkg.sv
exe_stage_reg.sv
exe_alu.sv
exe_div.sv
exe_mem_req.sv
exe_stage.sv
exe_stage_chk.sv
tb_exe_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exe_stage
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "sim passed" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
